//--- common/sched_pkg.sv
`default_nettype none

package sched_pkg;

    // program store geometry
    localparam int PROG_DEPTH = 256;
    localparam int WORD_W     = 16;
    localparam int FRAME_LEN  = 16;
    localparam int ADDR_W     = 8;
    localparam int OFS_W      = $clog2(FRAME_LEN);  // word offset inside a frame
    localparam int FRAME_W    = ADDR_W - OFS_W;     // frame number part of an address

    // word positions inside a header frame
    localparam logic [OFS_W-1:0] HDR_WORD_CTRL  = 0;
    localparam logic [OFS_W-1:0] HDR_WORD_MASK  = 1;
    localparam logic [OFS_W-1:0] HDR_WORD_R0VEC = 2;

    // fields of header word 0
    localparam int IFNUM_LSB = 0;   // count of instruction frames
    localparam int IFNUM_W   = 6;
    localparam int FENCE_LSB = 6;
    localparam int FENCE_W   = 2;

    typedef enum logic [FENCE_W-1:0] {
        FENCE_NONE = 2'd0,
        FENCE_ACQ  = 2'd1,  // wait for own cores before the next task
        FENCE_REL  = 2'd2   // start only on a fully idle array
    } fence_e;

    // kind of each word put on the core bus
    typedef enum logic [1:0] {
        MSG_R0_VEC  = 2'd0,
        MSG_R0_DATA = 2'd1,
        MSG_INSTR   = 2'd2
    } msg_kind_e;

endpackage

`default_nettype wire

//--- common/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int CORE_NUM = 8;    // core mask sits in the low bits of a word

    // instruction word layout
    localparam int OPC_LSB = 12;
    localparam int OPC_W   = 4;
    localparam int ARG_W   = 12;    // operand, bits 11 to 0

    typedef enum logic [OPC_W-1:0] {
        OP_NOP   = 4'd0,
        OP_ALU   = 4'd1,
        OP_LOAD  = 4'd2,
        OP_STORE = 4'd3,
        OP_END   = 4'd4     // operand is the drain time in cycles
    } core_op_e;

endpackage

`default_nettype wire

//--- logic/prog_store.sv
`timescale 1ns/1ns
`default_nettype none

module prog_store import sched_pkg::*; (
    input  wire               clk,
    input  wire               prog_loading,
    input  wire  [ADDR_W-1:0] load_addr,
    input  wire  [WORD_W-1:0] load_data,
    input  wire  [ADDR_W-1:0] rd_addr,
    output logic [WORD_W-1:0] rd_data
);

    logic [WORD_W-1:0] mem [PROG_DEPTH];

    // host writes one word per cycle during the load phase
    always_ff @(posedge clk) begin
        if (prog_loading) begin
            mem[load_addr] <= load_data;
        end
    end

    assign rd_data = mem[rd_addr];  // same-cycle read for the scheduler

endmodule

`default_nettype wire

//--- scheduler/task_gate.sv
`timescale 1ns/1ns
`default_nettype none

module task_gate import sched_pkg::*, core_pkg::*; (
    input  wire                clk,
    input  wire                reset,
    input  wire                hdr_ctrl_load,
    input  wire                hdr_mask_load,
    input  wire  [WORD_W-1:0]  hdr_word,
    input  wire                task_done,
    input  wire  [CORE_NUM-1:0] core_ready,
    output logic               go_r0,
    output logic               go_next
);

    fence_e              fence;         // fence of the current task
    logic [CORE_NUM-1:0] task_mask;     // cores the current task uses
    logic                acq_wait;
    logic                mask_idle;
    logic                all_idle;

    assign mask_idle = (task_mask & ~core_ready) == '0;
    assign all_idle  = &core_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            fence     <= FENCE_NONE;
            task_mask <= '0;
            acq_wait  <= 1'b0;
        end else begin
            if (hdr_ctrl_load) begin
                fence <= fence_e'(hdr_word[FENCE_LSB +: FENCE_W]);
            end
            if (hdr_mask_load) begin
                task_mask <= hdr_word[CORE_NUM-1:0];
            end
            // an acquire task blocks the next header until its cores drain
            if (task_done && fence == FENCE_ACQ) begin
                acq_wait <= 1'b1;
            end else if (acq_wait && mask_idle) begin
                acq_wait <= 1'b0;
            end
        end
    end

    assign go_r0   = mask_idle && !(fence == FENCE_REL && !all_idle);
    assign go_next = !acq_wait || mask_idle;   // lets go as soon as the cores are back

endmodule

`default_nettype wire

//--- scheduler/scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module scheduler import sched_pkg::*, core_pkg::*; (
    input  wire               clk,
    input  wire               reset,
    input  wire               prog_loading,
    input  wire               core_reading,
    output logic [ADDR_W-1:0] rd_addr,
    input  wire  [WORD_W-1:0] rd_data,
    input  wire               go_r0,
    input  wire               go_next,
    output logic              hdr_ctrl_load,
    output logic              hdr_mask_load,
    output logic [WORD_W-1:0] hdr_word,
    output logic              task_done,
    output logic [WORD_W-1:0] mess_to_core,
    output msg_kind_e         mess_kind,
    output logic              frame_being_sent,
    output logic              done
);

    typedef enum logic [1:0] {
        ST_HDR,     // header frame of a task
        ST_INSTR,   // counted instruction frames
        ST_DONE
    } state_e;

    state_e               state;
    logic [FRAME_W-1:0]   frame_ptr;
    logic [OFS_W-1:0]     word_ofs;
    logic [IFNUM_W-1:0]   if_cnt;       // instruction frames left

    logic      in_hdr;
    logic      last_word;
    logic      stall;
    logic      step;
    logic      send;
    logic      terminate;
    msg_kind_e kind_next;

    assign rd_addr   = {frame_ptr, word_ofs};
    assign hdr_word  = rd_data;
    assign in_hdr    = state == ST_HDR;
    assign last_word = word_ofs == OFS_W'(FRAME_LEN - 1);

    // wait for the gate at the start of a header and before the r0 vector
    assign stall = in_hdr &&
                   ((word_ofs == HDR_WORD_CTRL && !go_next) ||
                    (word_ofs == HDR_WORD_R0VEC && !go_r0));

    assign step = !prog_loading && core_reading && state != ST_DONE && !stall;

    // header words 0 and 1 are consumed here and never sent
    assign send = step && !(in_hdr && (word_ofs == HDR_WORD_CTRL ||
                                       word_ofs == HDR_WORD_MASK));

    assign hdr_ctrl_load = step && in_hdr && word_ofs == HDR_WORD_CTRL;
    assign hdr_mask_load = step && in_hdr && word_ofs == HDR_WORD_MASK;

    // no instruction frames and no cores means end of program
    assign terminate = hdr_mask_load && if_cnt == '0 && rd_data[CORE_NUM-1:0] == '0;

    assign task_done = step && last_word &&
                       ((in_hdr && if_cnt == '0) ||
                        (state == ST_INSTR && if_cnt == IFNUM_W'(1)));

    always_comb begin
        if (!in_hdr) begin
            kind_next = MSG_INSTR;
        end else if (word_ofs == HDR_WORD_R0VEC) begin
            kind_next = MSG_R0_VEC;
        end else begin
            kind_next = MSG_R0_DATA;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state            <= ST_HDR;
            frame_ptr        <= '0;
            word_ofs         <= '0;
            if_cnt           <= '0;
            frame_being_sent <= 1'b0;
            done             <= 1'b0;
        end else begin
            frame_being_sent <= send;
            if (step) begin
                word_ofs <= word_ofs + 1'b1;    // wraps into the next frame
                if (last_word) begin
                    frame_ptr <= frame_ptr + 1'b1;
                end
                case (state)
                    ST_HDR: begin
                        if (hdr_ctrl_load) begin
                            if_cnt <= rd_data[IFNUM_LSB +: IFNUM_W];
                        end
                        if (terminate) begin
                            state <= ST_DONE;
                            done  <= 1'b1;
                        end else if (last_word && if_cnt != '0) begin
                            state <= ST_INSTR;
                        end
                    end
                    ST_INSTR: begin
                        if (last_word) begin
                            if_cnt <= if_cnt - 1'b1;
                            if (if_cnt == IFNUM_W'(1)) begin
                                state <= ST_HDR;
                            end
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // output word register, holds its value while nothing is sent
    always_ff @(posedge clk) begin
        if (reset) begin
            mess_to_core <= '0;
            mess_kind    <= MSG_R0_VEC;
        end else if (send) begin
            mess_to_core <= rd_data;
            mess_kind    <= kind_next;
        end
    end

endmodule

`default_nettype wire

//--- logic/core_array.sv
`timescale 1ns/1ns
`default_nettype none

module core_array import sched_pkg::*, core_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire  [WORD_W-1:0]   mess_to_core,
    input  wire  msg_kind_e     mess_kind,
    input  wire                 frame_being_sent,
    output logic [CORE_NUM-1:0] core_ready
);

    logic [CORE_NUM-1:0] busy;
    logic [CORE_NUM-1:0] selected;      // cores named by the latest r0 vector
    logic [ARG_W-1:0]    drain_cnt [CORE_NUM];

    core_op_e         opcode;
    logic [ARG_W-1:0] drain;
    logic             r0_vec_msg;
    logic             end_msg;

    assign opcode     = core_op_e'(mess_to_core[OPC_LSB +: OPC_W]);
    assign drain      = mess_to_core[ARG_W-1:0];
    assign r0_vec_msg = frame_being_sent && mess_kind == MSG_R0_VEC;
    assign end_msg    = frame_being_sent && mess_kind == MSG_INSTR && opcode == OP_END;

    always_ff @(posedge clk) begin
        if (reset) begin
            busy     <= '0;
            selected <= '0;
            for (int i = 0; i < CORE_NUM; i++) begin
                drain_cnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < CORE_NUM; i++) begin
                if (r0_vec_msg) begin
                    selected[i] <= mess_to_core[i];
                    if (mess_to_core[i]) begin
                        busy[i] <= 1'b1;
                    end
                end
                if (end_msg && selected[i]) begin
                    if (drain == '0) begin
                        busy[i]     <= 1'b0;    // zero drain frees at once
                        selected[i] <= 1'b0;
                    end else begin
                        drain_cnt[i] <= drain;
                    end
                end else if (drain_cnt[i] == ARG_W'(1)) begin
                    busy[i]      <= 1'b0;
                    selected[i]  <= 1'b0;
                    drain_cnt[i] <= '0;
                end else if (drain_cnt[i] != '0) begin
                    drain_cnt[i] <= drain_cnt[i] - 1'b1;
                end
            end
        end
    end

    assign core_ready = ~busy;  // high = idle

endmodule

`default_nettype wire

//--- logic/gpu_sched_top.sv
`timescale 1ns/1ns
`default_nettype none

module gpu_sched_top import sched_pkg::*, core_pkg::*; (
    input  wire                 clk,
    input  wire                 reset,
    input  wire                 prog_loading,
    input  wire  [ADDR_W-1:0]   load_addr,
    input  wire  [WORD_W-1:0]   load_data,
    input  wire                 core_reading,
    output wire  [WORD_W-1:0]   mess_to_core,
    output wire  msg_kind_e     mess_kind,
    output wire                 frame_being_sent,
    output wire  [CORE_NUM-1:0] core_ready,
    output wire                 done
);

    wire [ADDR_W-1:0] rd_addr;
    wire [WORD_W-1:0] rd_data;
    wire              go_r0;
    wire              go_next;
    wire              hdr_ctrl_load;
    wire              hdr_mask_load;
    wire [WORD_W-1:0] hdr_word;
    wire              task_done;

    prog_store prog_store_i (
        .clk          (clk),
        .prog_loading (prog_loading),
        .load_addr    (load_addr),
        .load_data    (load_data),
        .rd_addr      (rd_addr),
        .rd_data      (rd_data)
    );

    scheduler scheduler_i (
        .clk              (clk),
        .reset            (reset),
        .prog_loading     (prog_loading),
        .core_reading     (core_reading),
        .rd_addr          (rd_addr),
        .rd_data          (rd_data),
        .go_r0            (go_r0),
        .go_next          (go_next),
        .hdr_ctrl_load    (hdr_ctrl_load),
        .hdr_mask_load    (hdr_mask_load),
        .hdr_word         (hdr_word),
        .task_done        (task_done),
        .mess_to_core     (mess_to_core),
        .mess_kind        (mess_kind),
        .frame_being_sent (frame_being_sent),
        .done             (done)
    );

    task_gate task_gate_i (
        .clk           (clk),
        .reset         (reset),
        .hdr_ctrl_load (hdr_ctrl_load),
        .hdr_mask_load (hdr_mask_load),
        .hdr_word      (hdr_word),
        .task_done     (task_done),
        .core_ready    (core_ready),
        .go_r0         (go_r0),
        .go_next       (go_next)
    );

    // behavioural cores, they produce core_ready from the message stream
    core_array core_array_i (
        .clk              (clk),
        .reset            (reset),
        .mess_to_core     (mess_to_core),
        .mess_kind        (mess_kind),
        .frame_being_sent (frame_being_sent),
        .core_ready       (core_ready)
    );

endmodule

`default_nettype wire

//--- tests/sched_tb_tasks.svh
`ifndef SCHED_TB_TASKS_SVH
`define SCHED_TB_TASKS_SVH

    // report the first error and end the run
    task automatic abort_run(input string what);
        $display("%s", what);
        $display("CHECKS FAILED");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_word(input string name, input logic [WORD_W-1:0] got,
                              input logic [WORD_W-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_kind(input string name, input msg_kind_e got, input msg_kind_e want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_mask(input string name, input logic [CORE_NUM-1:0] got,
                              input logic [CORE_NUM-1:0] want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic want);
        if (got !== want) begin
            abort_run($sformatf("FAILED %s got 0x%h expected 0x%h", name, got, want));
        end
    endtask

    // the task's cores must have been idle in the cycle that released its r0 vector
    task automatic check_r0_gate(input logic [CORE_NUM-1:0] ready_before,
                                 input logic [CORE_NUM-1:0] mask, input fence_e fence);
        check_mask("core_ready", ready_before & mask, mask);
        if (fence == FENCE_REL) begin
            check_mask("core_ready", ready_before, '1);   // release waits for the whole array
        end
    endtask

`endif

//--- tests/sched_tb.sv
`timescale 1ns/1ns
`default_nettype none

module sched_tb
    import sched_pkg::*, core_pkg::*;
();

    localparam int CLK_PERIOD  = 100;
    localparam int TDATA_DEPTH = 512;
    localparam int EXP_BASE    = 256;   // expected stream follows the program image
    localparam int RUN_TIMEOUT = 4000;  // cycles allowed until done
    localparam int TAIL_CYCLES = 10;

    logic                clk;
    logic                reset;
    logic                prog_loading;
    logic [ADDR_W-1:0]   load_addr;
    logic [WORD_W-1:0]   load_data;
    logic                core_reading;
    logic [WORD_W-1:0]   mess_to_core;
    msg_kind_e           mess_kind;
    logic                frame_being_sent;
    logic [CORE_NUM-1:0] core_ready;
    logic                done;

    logic [19:0]         tdata [TDATA_DEPTH];   // {kind, word} in the stream part
    int                  n_exp;
    int                  exp_idx;
    int                  next_hdr;              // header of the next task in the image
    fence_e              cur_fence;
    logic [CORE_NUM-1:0] cur_mask;
    logic [CORE_NUM-1:0] acq_mask;
    logic                acq_pending;           // acquire task ended but its cores are not yet idle
    logic                prev_reading;
    logic [CORE_NUM-1:0] prev_ready;

    gpu_sched_top gpu_sched_top_i (
        .clk              (clk),
        .reset            (reset),
        .prog_loading     (prog_loading),
        .load_addr        (load_addr),
        .load_data        (load_data),
        .core_reading     (core_reading),
        .mess_to_core     (mess_to_core),
        .mess_kind        (mess_kind),
        .frame_being_sent (frame_being_sent),
        .core_ready       (core_ready),
        .done             (done)
    );

    `include "sched_tb_tasks.svh"

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // one sample per cycle at the falling edge where outputs are stable
    task automatic monitor_cycle();
        logic [19:0] want;
        logic [3:0]  next_kind;
        if (!prev_reading) begin
            check_bit("frame_being_sent", frame_being_sent, 1'b0);
        end
        if (frame_being_sent) begin
            if (exp_idx >= n_exp) begin
                abort_run("a word was sent after the end of the expected stream");
            end
            want = tdata[EXP_BASE + exp_idx];
            check_word("mess_to_core", mess_to_core, want[WORD_W-1:0]);
            check_kind("mess_kind", mess_kind, msg_kind_e'(want[17:16]));
            if (mess_kind == MSG_R0_VEC) begin
                cur_fence = fence_e'(tdata[next_hdr][FENCE_LSB +: FENCE_W]);
                cur_mask  = tdata[next_hdr + HDR_WORD_MASK][CORE_NUM-1:0];
                next_hdr += FRAME_LEN * (1 + tdata[next_hdr][IFNUM_LSB +: IFNUM_W]);
                check_r0_gate(prev_ready, cur_mask, cur_fence);
            end
            exp_idx++;
            // the end marker comes right after the last word of the final task
            next_kind = tdata[EXP_BASE + exp_idx][19:16];
            if (cur_fence == FENCE_ACQ && next_kind == 4'hF) begin
                acq_pending = 1'b1;
                acq_mask    = cur_mask;
            end
        end
        if (done && exp_idx != n_exp) begin
            abort_run("done rose before the whole expected stream was sent");
        end
        if (done && acq_pending) begin
            abort_run("done rose before the acquire-fenced cores went idle");
        end
        if (acq_pending && (core_ready & acq_mask) == acq_mask) begin
            acq_pending = 1'b0;
        end
        prev_ready = core_ready;
    endtask

    initial begin
        int cycles;
        void'($urandom(93));
        for (int i = 0; i < TDATA_DEPTH; i++) begin
            tdata[i] = 20'hA5000 ^ 20'(i);     // never reads as an end marker
        end
        $readmemh("tests/sched_testdata.txt", tdata);
        n_exp = 0;
        while (n_exp < TDATA_DEPTH - EXP_BASE && tdata[EXP_BASE + n_exp][19:16] != 4'hF) begin
            n_exp++;
        end

        reset        = 1'b1;
        prog_loading = 1'b0;
        load_addr    = '0;
        load_data    = '0;
        core_reading = 1'b0;
        exp_idx      = 0;
        next_hdr     = 0;
        cur_fence    = FENCE_NONE;
        cur_mask     = '0;
        acq_mask     = '0;
        acq_pending  = 1'b0;
        prev_reading = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        check_bit("frame_being_sent", frame_being_sent, 1'b0);
        check_bit("done", done, 1'b0);
        check_word("mess_to_core", mess_to_core, '0);
        check_mask("core_ready", core_ready, '1);

        // word-serial program load
        for (int a = 0; a < PROG_DEPTH; a++) begin
            prog_loading = 1'b1;
            load_addr    = ADDR_W'(a);
            load_data    = tdata[a][WORD_W-1:0];
            @(negedge clk);
        end
        prog_loading = 1'b0;
        prev_ready   = core_ready;

        cycles = 0;
        while (!done) begin
            if (cycles == RUN_TIMEOUT) begin
                abort_run("timeout while waiting for done");
            end
            core_reading = ($urandom % 4) != 0;    // back-pressure on about a quarter
            prev_reading = core_reading;
            @(negedge clk);
            monitor_cycle();
            cycles++;
        end

        // nothing more may be sent once done is up
        core_reading = 1'b1;
        repeat (TAIL_CYCLES) begin
            @(negedge clk);
            check_bit("frame_being_sent", frame_being_sent, 1'b0);
            check_bit("done", done, 1'b1);
        end
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- gpu_sched.f
+incdir+tests
common/sched_pkg.sv
common/core_pkg.sv
logic/prog_store.sv
scheduler/task_gate.sv
scheduler/scheduler.sv
logic/core_array.sv
logic/gpu_sched_top.sv
tests/sched_tb.sv

//--- Bender.yml
package:
  name: gpu_sched

sources:
  - common/sched_pkg.sv
  - common/core_pkg.sv
  - logic/prog_store.sv
  - scheduler/task_gate.sv
  - scheduler/scheduler.sv
  - logic/core_array.sv
  - logic/gpu_sched_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/sched_tb.sv

//--- tests/sched_testdata.txt
// @000 program image, 16 words per frame: ctrl, mask, r0 vector, r0 data, then instruction frames
// @100 expected stream, one entry per sent word: kind digit then word, F0000 ends it
@000
0001 0003 0003 A003 A004 A005 A006 A007 A008 A009 A00A A00B A00C A00D A00E A00F
1001 1002 2003 3004 0000 1005 1006 2007 3008 0000 1009 100A 200B 300C 0000 4030
0001 0006 0006 B003 B004 B005 B006 B007 B008 B009 B00A B00B B00C B00D B00E B00F
1101 1102 2103 3104 0000 1105 1106 2107 3108 0000 1109 110A 210B 310C 0000 4010
0081 0030 0030 C003 C004 C005 C006 C007 C008 C009 C00A C00B C00C C00D C00E C00F
1201 1202 2203 3204 0000 1205 1206 2207 3208 0000 1209 120A 220B 320C 0000 4008
0042 00C0 00C0 D003 D004 D005 D006 D007 D008 D009 D00A D00B D00C D00D D00E D00F
1301 2302 3303 0000 1304 2305 3306 0000 1307 2308 3309 0000 130A 230B 330C 130D
1311 2312 3313 0000 1314 2315 3316 0000 1317 2318 3319 0000 131A 231B 331C 4020
0000 0000
@100
00003 1A003 1A004 1A005 1A006 1A007 1A008 1A009 1A00A 1A00B 1A00C 1A00D 1A00E 1A00F
21001 21002 22003 23004 20000 21005 21006 22007 23008 20000 21009 2100A 2200B 2300C 20000 24030
00006 1B003 1B004 1B005 1B006 1B007 1B008 1B009 1B00A 1B00B 1B00C 1B00D 1B00E 1B00F
21101 21102 22103 23104 20000 21105 21106 22107 23108 20000 21109 2110A 2210B 2310C 20000 24010
00030 1C003 1C004 1C005 1C006 1C007 1C008 1C009 1C00A 1C00B 1C00C 1C00D 1C00E 1C00F
21201 21202 22203 23204 20000 21205 21206 22207 23208 20000 21209 2120A 2220B 2320C 20000 24008
000C0 1D003 1D004 1D005 1D006 1D007 1D008 1D009 1D00A 1D00B 1D00C 1D00D 1D00E 1D00F
21301 22302 23303 20000 21304 22305 23306 20000 21307 22308 23309 20000 2130A 2230B 2330C 2130D
21311 22312 23313 20000 21314 22315 23316 20000 21317 22318 23319 20000 2131A 2231B 2331C 24020
F0000
